//--- tests/chip_shim_stimulus.txt
# name rst gpio_p2d in_pins mio_out mio_oe pull_en pull_sel dio_out dio_oe, then expected
#   gpio_d2p gpio_en pull_en pull_sel mio_in dio_in out_pins por_n, all hex except pins
# in_pins rx sck csb sdi sense dp dn, out_pins tx tx_en sdo sdo_en dp dp_en dn dn_en
idle 0 0 0000000 0 0 0 0 0 0 0 0 0 0 0 0 00000000 0
gpio_in_all 0 ffffffff 0000000 0 0 0 0 0 0 0 0 0 0 7ffff 0 00000000 0
gpio_in_unmapped 0 b63fc000 0000000 0 0 0 0 0 0 0 0 0 0 0 0 00000000 0
gpio_in_tap0 0 40000000 0000000 0 0 0 0 0 0 0 0 0 0 20000 0 00000000 0
gpio_in_tap1 0 08000000 0000000 0 0 0 0 0 0 0 0 0 0 40000 0 00000000 0
gpio_in_sw1 0 00800000 0000000 0 0 0 0 0 0 0 0 0 0 8000 0 00000000 0
gpio_in_generic 0 00002a55 0000000 0 0 0 0 0 0 0 0 0 0 2a55 0 00000000 0
uart_rx_in 0 0 1000000 0 0 0 0 0 0 0 0 0 0 80000 0 00000000 1
usb_sense_in 0 0 0000100 0 0 0 0 0 0 0 0 0 0 200000 0 00000000 1
dio_in_all 0 0 0111011 0 0 0 0 0 0 0 0 0 0 0 37 00000000 0
dio_in_sck 0 0 0100000 0 0 0 0 0 0 0 0 0 0 0 1 00000000 0
dio_in_dn 0 0 0000001 0 0 0 0 0 0 0 0 0 0 0 20 00000000 0
mio_out_all 0 0 0000000 3fffff 0 0 0 0 0 49c03fff 0 0 0 0 0 10000000 0
mio_oe_all 0 0 0000000 0 3fffff 0 0 0 0 0 49c03fff 0 0 0 0 01000000 0
pull_en_all 0 0 0000000 0 0 3fffff 0 0 0 0 0 49c03fff 0 0 0 00000000 0
pull_sel_all 0 0 0000000 0 0 0 3fffff 0 0 0 0 0 49c03fff 0 0 00000000 1
rst_assert 1 0 0000000 20000 0 0 0 0 0 40000000 0 0 0 0 0 00000000 1
rst_hold 1 0 0000000 40000 0 0 0 0 0 08000000 0 0 0 0 0 00000000 0
rst_release 0 0 0000000 0 4000 0 0 0 0 0 00400000 0 0 0 0 00000000 0
pull_sel_sw2 0 0 0000000 0 0 0 10000 0 0 0 0 0 01000000 0 0 00000000 0
mio_out_uart_tx 0 0 0000000 100000 0 0 0 0 0 0 0 0 0 0 0 10000000 0
sdo_out 0 0 0000000 0 0 0 0 8 0 0 0 0 0 0 0 00100000 0
sdo_en 0 0 0000000 0 0 0 0 0 8 0 0 0 0 0 0 00010000 0
dp_out 0 0 0000000 0 0 0 0 10 0 0 0 0 0 0 0 00001000 0
dp_en 0 0 0000000 0 0 0 0 0 10 0 0 0 0 0 0 00000100 0
dn_out 0 0 0000000 0 0 0 0 20 0 0 0 0 0 0 0 00000010 1
dn_en 0 0 0000000 0 0 0 0 0 20 0 0 0 0 0 0 00000001 1
dio_no_sdo 0 0 0000000 0 0 0 0 7 7 0 0 0 0 0 0 00000000 0
dio_all 0 0 0000000 0 0 0 0 3f 3f 0 0 0 0 0 0 00111111 0
all_ones 0 ffffffff 1111111 3fffff 3fffff 0 0 3f 3f 49c03fff 49c03fff 0 0 2fffff 37 11111111 0
mio_out_rx 0 0 0000000 80000 0 0 0 0 0 0 0 0 0 0 0 00000000 0
mio_out_sense 0 0 0000000 200000 0 0 0 0 0 0 0 0 0 0 0 00000000 0
pull_en_tx 0 0 0000000 0 0 100000 0 0 0 0 0 0 0 0 0 00000000 0
mio_out_generic 0 0 0000000 1234 0 0 0 0 0 00001234 0 0 0 0 0 00000000 1

//--- chip_shim.f
hdl/chip_shim_pkg.sv
hdl/supply_ramp.sv
hdl/pok_filter.sv
hdl/pad_ring.sv
hdl/chip_shim.sv
tests/chip_shim_tb.sv

//--- Makefile
# Verilator build and run of the chip shim testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := chip_shim_tb
FILELIST  := chip_shim.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := RESULT: PASS

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/chip_shim_tb.sv
/*
  chip shim testbench
  replays stimulus records and checks pad routing and the por_n sequence
*/
`default_nettype none

module chip_shim_tb import chip_shim_pkg::*; ();

  localparam int ClkPeriod   = 100;
  localparam int DriveDelay  = 10;
  localparam int SampleDelay = 80;
  localparam int ResetCycles = 3;
  localparam     StimFile    = "tests/chip_shim_stimulus.txt";

  logic clk_aon;
  logic rst_i;
  logic por_n_o;

  // pad side
  logic [GpioWidth-1:0] gpio_p2d_i;
  logic [GpioWidth-1:0] gpio_d2p_o;
  logic [GpioWidth-1:0] gpio_en_d2p_o;
  logic [GpioWidth-1:0] gpio_pull_en_o;
  logic [GpioWidth-1:0] gpio_pull_sel_o;
  logic uart_rx_p2d_i, uart_tx_d2p_o, uart_tx_en_d2p_o;
  logic spi_sck_p2d_i, spi_csb_p2d_i, spi_sdi_p2d_i;
  logic spi_sdo_d2p_o, spi_sdo_en_d2p_o;
  logic usb_sense_p2d_i, usb_dp_p2d_i, usb_dn_p2d_i;
  logic usb_dp_d2p_o, usb_dp_en_d2p_o, usb_dn_d2p_o, usb_dn_en_d2p_o;

  // core side
  logic [NMioPads-1:0] mio_out_i;
  logic [NMioPads-1:0] mio_oe_i;
  logic [NMioPads-1:0] mio_pull_en_i;
  logic [NMioPads-1:0] mio_pull_sel_i;
  logic [NMioPads-1:0] mio_in_o;
  logic [NDioPads-1:0] dio_out_i;
  logic [NDioPads-1:0] dio_oe_i;
  logic [NDioPads-1:0] dio_in_o;

  // record lines, comments and blank lines dropped
  string records[$];
  int    cycles     = 0;
  int    max_cycles = 0;

  chip_shim #(
    .PokStableCycles (3)
  ) i_chip_shim (
    .*
  );

  initial begin
    clk_aon = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk_aon = ~clk_aon;
    end
  end

  // run length guard, armed once the records are loaded
  always @(posedge clk_aon) begin
    cycles <= cycles + 1;
    if (max_cycles != 0 && cycles >= max_cycles) begin
      $display("timeout: run still going after %0d cycles", cycles);
      abort_run();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_gpio(input string test, input string sig,
                            input logic [GpioWidth-1:0] expected,
                            input logic [GpioWidth-1:0] actual);
    if (actual !== expected) begin
      $display("Fail %s %s: expected %h actual %h", test, sig, expected, actual);
      abort_run();
    end
  endtask

  // dio vectors come in zero extended
  task automatic check_mio(input string test, input string sig,
                           input logic [NMioPads-1:0] expected,
                           input logic [NMioPads-1:0] actual);
    if (actual !== expected) begin
      $display("Fail %s %s: expected %h actual %h", test, sig, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_bit(input string test, input string sig,
                           input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Fail %s %s: expected %b actual %b", test, sig, expected, actual);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic load_records();
    int    fd;
    string line;
    fd = $fopen(StimFile, "r");
    if (fd == 0) begin
      $display("cannot open stimulus file %s", StimFile);
      abort_run();
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
          records.push_back(line);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_record(input string line);
    string                name;
    logic                 rst;
    logic                 exp_por;
    logic [6:0]           pins_in;
    logic [7:0]           pins_out;
    logic [GpioWidth-1:0] gpio_in, exp_d2p, exp_en, exp_pull_en, exp_pull_sel;
    logic [NMioPads-1:0]  m_out, m_oe, m_pull_en, m_pull_sel, exp_mio_in;
    logic [NDioPads-1:0]  d_out, d_oe, exp_dio_in;
    int                   n;
    n = $sscanf(line, "%s %b %h %b %h %h %h %h %h %h %h %h %h %h %h %h %b %b",
                name, rst, gpio_in, pins_in, m_out, m_oe, m_pull_en, m_pull_sel,
                d_out, d_oe, exp_d2p, exp_en, exp_pull_en, exp_pull_sel,
                exp_mio_in, exp_dio_in, pins_out, exp_por);
    if (n != 18) begin
      $display("stimulus line could not be read: %s", line);
      abort_run();
    end else begin
      rst_i      = rst;
      gpio_p2d_i = gpio_in;
      {uart_rx_p2d_i, spi_sck_p2d_i, spi_csb_p2d_i, spi_sdi_p2d_i,
       usb_sense_p2d_i, usb_dp_p2d_i, usb_dn_p2d_i} = pins_in;
      mio_out_i      = m_out;
      mio_oe_i       = m_oe;
      mio_pull_en_i  = m_pull_en;
      mio_pull_sel_i = m_pull_sel;
      dio_out_i      = d_out;
      dio_oe_i       = d_oe;

      // look just before the next edge
      #(SampleDelay);
      check_gpio(name, "gpio_d2p_o", exp_d2p, gpio_d2p_o);
      check_gpio(name, "gpio_en_d2p_o", exp_en, gpio_en_d2p_o);
      check_gpio(name, "gpio_pull_en_o", exp_pull_en, gpio_pull_en_o);
      check_gpio(name, "gpio_pull_sel_o", exp_pull_sel, gpio_pull_sel_o);
      check_mio(name, "mio_in_o", exp_mio_in, mio_in_o);
      check_mio(name, "dio_in_o", NMioPads'(exp_dio_in), NMioPads'(dio_in_o));
      check_bit(name, "uart_tx_d2p_o", pins_out[7], uart_tx_d2p_o);
      check_bit(name, "uart_tx_en_d2p_o", pins_out[6], uart_tx_en_d2p_o);
      check_bit(name, "spi_sdo_d2p_o", pins_out[5], spi_sdo_d2p_o);
      check_bit(name, "spi_sdo_en_d2p_o", pins_out[4], spi_sdo_en_d2p_o);
      check_bit(name, "usb_dp_d2p_o", pins_out[3], usb_dp_d2p_o);
      check_bit(name, "usb_dp_en_d2p_o", pins_out[2], usb_dp_en_d2p_o);
      check_bit(name, "usb_dn_d2p_o", pins_out[1], usb_dn_d2p_o);
      check_bit(name, "usb_dn_en_d2p_o", pins_out[0], usb_dn_en_d2p_o);
      check_bit(name, "por_n_o", exp_por, por_n_o);
    end
  endtask

  initial begin
    rst_i      = 1'b1;
    gpio_p2d_i = '0;
    {uart_rx_p2d_i, spi_sck_p2d_i, spi_csb_p2d_i, spi_sdi_p2d_i,
     usb_sense_p2d_i, usb_dp_p2d_i, usb_dn_p2d_i} = '0;
    mio_out_i      = '0;
    mio_oe_i       = '0;
    mio_pull_en_i  = '0;
    mio_pull_sel_i = '0;
    dio_out_i      = '0;
    dio_oe_i       = '0;

    load_records();
    if (records.size() == 0) begin
      $display("stimulus file %s holds no records", StimFile);
      abort_run();
    end else begin
      max_cycles = 2 * records.size() + 20;
      repeat (ResetCycles) @(posedge clk_aon);
      // record k sees the state after edge k, edge 0 being the last reset edge
      foreach (records[i]) begin
        #(DriveDelay);
        run_record(records[i]);
        @(posedge clk_aon);
      end
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule : chip_shim_tb

`default_nettype wire

//--- hdl/chip_shim.sv
/*
  chip shim top level
  pad ring plus the fake supply and power-ok chain that makes por_n
*/
`default_nettype none

module chip_shim import chip_shim_pkg::*; #(
  parameter int unsigned PokStableCycles = 3
) (
  input  logic                 clk_aon,
  input  logic                 rst_i,

  // gpio
  input  logic [GpioWidth-1:0] gpio_p2d_i,
  output logic [GpioWidth-1:0] gpio_d2p_o,
  output logic [GpioWidth-1:0] gpio_en_d2p_o,
  output logic [GpioWidth-1:0] gpio_pull_en_o,
  output logic [GpioWidth-1:0] gpio_pull_sel_o,

  // uart
  input  logic                 uart_rx_p2d_i,
  output logic                 uart_tx_d2p_o,
  output logic                 uart_tx_en_d2p_o,

  // spi device
  input  logic                 spi_sck_p2d_i,
  input  logic                 spi_csb_p2d_i,
  input  logic                 spi_sdi_p2d_i,
  output logic                 spi_sdo_d2p_o,
  output logic                 spi_sdo_en_d2p_o,

  // usb
  input  logic                 usb_sense_p2d_i,
  input  logic                 usb_dp_p2d_i,
  input  logic                 usb_dn_p2d_i,
  output logic                 usb_dp_d2p_o,
  output logic                 usb_dp_en_d2p_o,
  output logic                 usb_dn_d2p_o,
  output logic                 usb_dn_en_d2p_o,

  // core side
  input  logic [NMioPads-1:0]  mio_out_i,
  input  logic [NMioPads-1:0]  mio_oe_i,
  input  logic [NMioPads-1:0]  mio_pull_en_i,
  input  logic [NMioPads-1:0]  mio_pull_sel_i,
  output logic [NMioPads-1:0]  mio_in_o,
  input  logic [NDioPads-1:0]  dio_out_i,
  input  logic [NDioPads-1:0]  dio_oe_i,
  output logic [NDioPads-1:0]  dio_in_o,

  // power-on reset to the core
  output logic                 por_n_o
);

  //////////////////////////////////////////////////////////////////////
  // pad routing
  //////////////////////////////////////////////////////////////////////

  pad_ring i_pad_ring (
    .gpio_p2d_i       (gpio_p2d_i),
    .uart_rx_p2d_i    (uart_rx_p2d_i),
    .spi_sck_p2d_i    (spi_sck_p2d_i),
    .spi_csb_p2d_i    (spi_csb_p2d_i),
    .spi_sdi_p2d_i    (spi_sdi_p2d_i),
    .usb_sense_p2d_i  (usb_sense_p2d_i),
    .usb_dp_p2d_i     (usb_dp_p2d_i),
    .usb_dn_p2d_i     (usb_dn_p2d_i),
    .gpio_d2p_o       (gpio_d2p_o),
    .gpio_en_d2p_o    (gpio_en_d2p_o),
    .gpio_pull_en_o   (gpio_pull_en_o),
    .gpio_pull_sel_o  (gpio_pull_sel_o),
    .uart_tx_d2p_o    (uart_tx_d2p_o),
    .uart_tx_en_d2p_o (uart_tx_en_d2p_o),
    .spi_sdo_d2p_o    (spi_sdo_d2p_o),
    .spi_sdo_en_d2p_o (spi_sdo_en_d2p_o),
    .usb_dp_d2p_o     (usb_dp_d2p_o),
    .usb_dp_en_d2p_o  (usb_dp_en_d2p_o),
    .usb_dn_d2p_o     (usb_dn_d2p_o),
    .usb_dn_en_d2p_o  (usb_dn_en_d2p_o),
    .mio_out_i        (mio_out_i),
    .mio_oe_i         (mio_oe_i),
    .mio_pull_en_i    (mio_pull_en_i),
    .mio_pull_sel_i   (mio_pull_sel_i),
    .dio_out_i        (dio_out_i),
    .dio_oe_i         (dio_oe_i),
    .mio_in_o         (mio_in_o),
    .dio_in_o         (dio_in_o)
  );

  //////////////////////////////////////////////////////////////////////
  // power-on chain
  //////////////////////////////////////////////////////////////////////

  logic vcc_supp;

  supply_ramp i_supply_ramp (
    .clk_aon    (clk_aon),
    .rst_i      (rst_i),
    .vcc_supp_o (vcc_supp)
  );

  // filtered supply is the core reset, low while not ok
  pok_filter #(
    .PokStableCycles (PokStableCycles)
  ) i_pok_filter (
    .clk_aon  (clk_aon),
    .rst_i    (rst_i),
    .supply_i (vcc_supp),
    .pok_o    (por_n_o)
  );

endmodule : chip_shim

`default_nettype wire

//--- hdl/pad_ring.sv
/*
  pad ring routing
  maps pad-side gpio, uart, spi and usb pins onto the mio and dio banks
*/
`default_nettype none

module pad_ring import chip_shim_pkg::*; (
  // pad side, inputs
  input  logic [GpioWidth-1:0] gpio_p2d_i,
  input  logic                 uart_rx_p2d_i,
  input  logic                 spi_sck_p2d_i,
  input  logic                 spi_csb_p2d_i,
  input  logic                 spi_sdi_p2d_i,
  input  logic                 usb_sense_p2d_i,
  input  logic                 usb_dp_p2d_i,
  input  logic                 usb_dn_p2d_i,

  // pad side, outputs
  output logic [GpioWidth-1:0] gpio_d2p_o,
  output logic [GpioWidth-1:0] gpio_en_d2p_o,
  output logic [GpioWidth-1:0] gpio_pull_en_o,
  output logic [GpioWidth-1:0] gpio_pull_sel_o,
  output logic                 uart_tx_d2p_o,
  output logic                 uart_tx_en_d2p_o,
  output logic                 spi_sdo_d2p_o,
  output logic                 spi_sdo_en_d2p_o,
  output logic                 usb_dp_d2p_o,
  output logic                 usb_dp_en_d2p_o,
  output logic                 usb_dn_d2p_o,
  output logic                 usb_dn_en_d2p_o,

  // core side, from the core
  input  logic [NMioPads-1:0]  mio_out_i,
  input  logic [NMioPads-1:0]  mio_oe_i,
  input  logic [NMioPads-1:0]  mio_pull_en_i,
  input  logic [NMioPads-1:0]  mio_pull_sel_i,
  input  logic [NDioPads-1:0]  dio_out_i,
  input  logic [NDioPads-1:0]  dio_oe_i,

  // core side, to the core
  output logic [NMioPads-1:0]  mio_in_o,
  output logic [NDioPads-1:0]  dio_in_o
);

  //////////////////////////////////////////////////////////////////////
  // mio to gpio
  //////////////////////////////////////////////////////////////////////

  // same layout for data, enable and both pull attributes
  function automatic logic [GpioWidth-1:0] mio_to_gpio(
    input logic [NMioPads-1:0] mio
  );
    logic [GpioWidth-1:0] gpio;
    gpio = '0;
    gpio[GpioGenericBase +: NGenericGpio] = mio[MioGpioBase +: NGenericGpio];
    gpio[GpioSwStrapBase +: NSwStraps]    = mio[MioSwStrapBase +: NSwStraps];
    gpio[GpioTapStrap1Bit]                = mio[MioTapStrap1];
    gpio[GpioTapStrap0Bit]                = mio[MioTapStrap0];
    return gpio;
  endfunction

  assign gpio_d2p_o      = mio_to_gpio(mio_out_i);
  assign gpio_en_d2p_o   = mio_to_gpio(mio_oe_i);
  assign gpio_pull_en_o  = mio_to_gpio(mio_pull_en_i);
  assign gpio_pull_sel_o = mio_to_gpio(mio_pull_sel_i);

  // uart tx goes out on its own pin
  assign uart_tx_d2p_o    = mio_out_i[MioUartTx];
  assign uart_tx_en_d2p_o = mio_oe_i[MioUartTx];

  //////////////////////////////////////////////////////////////////////
  // pads to mio
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // tx pad and anything unmapped read back as 0
    mio_in_o = '0;

    // generic gpios
    mio_in_o[MioGpioBase +: NGenericGpio] = gpio_p2d_i[GpioGenericBase +: NGenericGpio];

    // sw straps
    mio_in_o[MioSwStrapBase +: NSwStraps] = gpio_p2d_i[GpioSwStrapBase +: NSwStraps];

    // tap straps
    mio_in_o[MioTapStrap0] = gpio_p2d_i[GpioTapStrap0Bit];
    mio_in_o[MioTapStrap1] = gpio_p2d_i[GpioTapStrap1Bit];

    mio_in_o[MioUartRx]   = uart_rx_p2d_i;
    mio_in_o[MioUsbSense] = usb_sense_p2d_i;
  end

  //////////////////////////////////////////////////////////////////////
  // dedicated pads
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // sdo is output only
    dio_in_o = '0;
    dio_in_o[DioSpiSck] = spi_sck_p2d_i;
    dio_in_o[DioSpiCsb] = spi_csb_p2d_i;
    dio_in_o[DioSpiSdi] = spi_sdi_p2d_i;
    dio_in_o[DioUsbDp]  = usb_dp_p2d_i;
    dio_in_o[DioUsbDn]  = usb_dn_p2d_i;
  end

  // spi device sdo
  assign spi_sdo_d2p_o    = dio_out_i[DioSpiSdo];
  assign spi_sdo_en_d2p_o = dio_oe_i[DioSpiSdo];

  // usb differential pair
  assign usb_dp_d2p_o    = dio_out_i[DioUsbDp];
  assign usb_dp_en_d2p_o = dio_oe_i[DioUsbDp];
  assign usb_dn_d2p_o    = dio_out_i[DioUsbDn];
  assign usb_dn_en_d2p_o = dio_oe_i[DioUsbDn];

endmodule : pad_ring

`default_nettype wire

//--- hdl/pok_filter.sv
/*
  power-ok filter
  raises pok after a run of high supply samples, drops it on any low one
*/
`default_nettype none

module pok_filter #(
  parameter int unsigned PokStableCycles = 3
) (
  input  logic clk_aon,
  input  logic rst_i,
  input  logic supply_i,
  output logic pok_o
);

  localparam int unsigned RunWidth = $clog2(PokStableCycles + 1);
  localparam logic [RunWidth-1:0] RunMax = RunWidth'(PokStableCycles);

  logic [RunWidth-1:0] run_q;
  logic [RunWidth-1:0] run_d;

  // consecutive high samples, saturating
  always_comb begin
    if (!supply_i) begin
      run_d = '0;
    end else if (run_q == RunMax) begin
      run_d = run_q;
    end else begin
      run_d = run_q + 1'b1;
    end
  end

  // compare against the updated run so pok rises on the last good sample
  always_ff @(posedge clk_aon) begin
    if (rst_i) begin
      run_q <= '0;
      pok_o <= 1'b0;
    end else begin
      run_q <= run_d;
      pok_o <= (run_d == RunMax);
    end
  end

endmodule : pok_filter

`default_nettype wire

//--- hdl/supply_ramp.sv
/*
  fake supply ramp
  saturating counter decoded into a low/high/low/high supply level
*/
`default_nettype none

module supply_ramp import chip_shim_pkg::*; (
  input  logic clk_aon,
  input  logic rst_i,
  output logic vcc_supp_o
);

  logic [SupplyCntWidth-1:0] cnt_q;

  // count up after reset, stop at the top
  always_ff @(posedge clk_aon) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (cnt_q != SupplyCntMax) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // glitch once during power-up, then stay up
  always_comb begin
    if (cnt_q < SupplyOn1) begin
      vcc_supp_o = 1'b0;
    end else if (cnt_q < SupplyOff) begin
      vcc_supp_o = 1'b1;
    end else if (cnt_q < SupplyOn2) begin
      vcc_supp_o = 1'b0;
    end else begin
      vcc_supp_o = 1'b1;
    end
  end

endmodule : supply_ramp

`default_nettype wire

//--- hdl/chip_shim_pkg.sv
/*
  chip shim shared constants
  pad bank sizes, pad and gpio bit positions, fake supply thresholds
*/
`default_nettype none

package chip_shim_pkg;

  //////////////////////////////////////////////////////////////////////
  // pad banks
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned NMioPads  = 22;
  localparam int unsigned NDioPads  = 6;
  localparam int unsigned GpioWidth = 32;

  // multiplexed pad indices
  localparam int unsigned MioGpioBase    = 0;
  localparam int unsigned MioSwStrapBase = 14;
  localparam int unsigned MioTapStrap0   = 17;
  localparam int unsigned MioTapStrap1   = 18;
  localparam int unsigned MioUartRx      = 19;
  localparam int unsigned MioUartTx      = 20;
  localparam int unsigned MioUsbSense    = 21;

  // dedicated pad indices
  localparam int unsigned DioSpiSck = 0;
  localparam int unsigned DioSpiCsb = 1;
  localparam int unsigned DioSpiSdi = 2;
  localparam int unsigned DioSpiSdo = 3;
  localparam int unsigned DioUsbDp  = 4;
  localparam int unsigned DioUsbDn  = 5;

  //////////////////////////////////////////////////////////////////////
  // gpio vector layout
  //////////////////////////////////////////////////////////////////////

  // generic gpios sit at the bottom of the vector
  localparam int unsigned GpioGenericBase = 0;
  localparam int unsigned NGenericGpio    = 14;

  // software straps
  localparam int unsigned GpioSwStrapBase = 22;
  localparam int unsigned NSwStraps       = 3;

  // tap straps, note strap 1 sits below strap 0
  localparam int unsigned GpioTapStrap1Bit = 27;
  localparam int unsigned GpioTapStrap0Bit = 30;

  //////////////////////////////////////////////////////////////////////
  // fake supply ramp
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned SupplyCntWidth = 4;

  // counter holds here
  localparam logic [SupplyCntWidth-1:0] SupplyCntMax = '1;

  // low below On1, high up to Off, low up to On2, then high for good
  localparam logic [SupplyCntWidth-1:0] SupplyOn1 = SupplyCntWidth'(4);
  localparam logic [SupplyCntWidth-1:0] SupplyOff = SupplyCntWidth'(8);
  localparam logic [SupplyCntWidth-1:0] SupplyOn2 = SupplyCntWidth'(12);

endpackage : chip_shim_pkg

`default_nettype wire
